/* common/rtc_macros.svh */
`ifndef RTC_MACROS_SVH
`define RTC_MACROS_SVH

////////////////////////////////////////////////
// Clock divisors
////////////////////////////////////////////////

// Cycles per second at 20 MHz
`define RTC_TICK_DIV 20_000_000

// Cycles between display scan steps, 1 kHz at 20 MHz
`define RTC_SCAN_DIV 20_000

////////////////////////////////////////////////
// Time limits
////////////////////////////////////////////////

`define RTC_HOURS_PER_DAY 24

// Serves minutes and seconds alike
`define RTC_MINUTES_PER_HOUR 60

`endif

/* common/rtc_pkg.sv */
package rtc_pkg;

    ////////////////////////////////////////////////
    // Digit type
    ////////////////////////////////////////////////

    // One BCD digit, 0 to 9
    typedef logic [3:0] bcd_t;

    ////////////////////////////////////////////////
    // Clock mode
    ////////////////////////////////////////////////

    // RUN counts time, the SET_* states select the field that
    // the inc button acts on
    typedef enum logic [1:0] {
        RUN      = 2'd0,
        SET_HOUR = 2'd1,
        SET_MIN  = 2'd2,
        SET_SEC  = 2'd3
    } set_field_t;

endpackage

/* dv/rtc_stimulus.txt */
# One command per line: run n (seconds), mode n / inc n (button pulses), en v (level)
# field v expects 0 RUN, 1 SET_HOUR, 2 SET_MIN, 3 SET_SEC; time hhmmss in hex BCD
field 0
time 000000
en 1
run 65
time 000105
en 0
run 7
time 000105
en 1
run 3
time 000108
mode 1
field 1
inc 21
time 210108
run 4
time 210108
inc 5
time 020108
mode 1
field 2
inc 58
time 025908
inc 1
time 020008
mode 1
field 3
inc 1
time 020000
mode 1
field 0
mode 1
inc 21
mode 1
inc 59
mode 2
field 0
time 235900
run 59
time 235959
run 1
time 000000

/* dv/rtc_tb.sv */
module rtc_tb;

    localparam int         TICK_DIV  = 10;
    localparam int         SCAN_DIV  = 3;
    localparam logic [5:0] SEL_FIRST = 6'b100000;

    logic                clk;
    logic                rst_n;
    logic                en;
    logic                mode_btn;
    logic                inc_btn;
    rtc_pkg::set_field_t field;
    rtc_pkg::bcd_t       hour_10;
    rtc_pkg::bcd_t       hour_1;
    rtc_pkg::bcd_t       minute_10;
    rtc_pkg::bcd_t       minute_1;
    rtc_pkg::bcd_t       second_10;
    rtc_pkg::bcd_t       second_1;
    logic [5:0]          digit_sel;
    rtc_pkg::bcd_t       digit_val;

    string       cmd_q[$];
    int unsigned arg_q[$];
    int          error_count = 0;
    int          check_count = 0;
    int          run_total   = 0;

    // Expected mode and prescaler position after the latest edge
    int model_field = 0;
    int phase       = 0;

    rtc_top #(
        .tick_div (TICK_DIV),
        .scan_div (SCAN_DIV)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .mode_btn  (mode_btn),
        .inc_btn   (inc_btn),
        .field     (field),
        .hour_10   (hour_10),
        .hour_1    (hour_1),
        .minute_10 (minute_10),
        .minute_1  (minute_1),
        .second_10 (second_10),
        .second_1  (second_1),
        .digit_sel (digit_sel),
        .digit_val (digit_val)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL at time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
        end
    endtask

    // hhmmss holds the six digits as hex nibbles
    task automatic check_time(input logic [23:0] hhmmss);
        check_value("hour_10", hour_10, hhmmss[23:20]);
        check_value("hour_1", hour_1, hhmmss[19:16]);
        check_value("minute_10", minute_10, hhmmss[15:12]);
        check_value("minute_1", minute_1, hhmmss[11:8]);
        check_value("second_10", second_10, hhmmss[7:4]);
        check_value("second_1", second_1, hhmmss[3:0]);
    endtask

    // Display order is hour tens first, second ones last
    function automatic rtc_pkg::bcd_t selected_digit(input logic [5:0] sel,
                                                     input logic [23:0] t);
        case (sel)
            6'b100000: return t[23:20];
            6'b010000: return t[19:16];
            6'b001000: return t[15:12];
            6'b000100: return t[11:8];
            6'b000010: return t[7:4];
            6'b000001: return t[3:0];
            default:   return 4'h0;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic read_stimulus();
        int          fd;
        int unsigned arg;
        string       line;
        string       cmd;
        fd = $fopen("dv/rtc_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file dv/rtc_stimulus.txt");
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            if ($sscanf(line, "%s", cmd) != 1) begin
                continue;
            end
            if ((cmd == "time") ? ($sscanf(line, "%s %h", cmd, arg) != 2)
                                : ($sscanf(line, "%s %d", cmd, arg) != 2)) begin
                $display("Stimulus line without an argument: %s", line);
                error_count++;
                continue;
            end
            cmd_q.push_back(cmd);
            arg_q.push_back(arg);
            if (cmd == "run") begin
                run_total += arg;
            end
        end
        $fclose(fd);
    endtask

    // One clock with the mode and prescaler model following along
    task automatic clock_step();
        @(posedge clk);
        if (model_field != 0 || phase == TICK_DIV - 1) begin
            phase = 0;
        end else begin
            phase++;
        end
        if (mode_btn) begin
            model_field = (model_field + 1) % 4;
        end
        #1;
    endtask

    // Waits for the n-th tick from the current prescaler position and then 2 more cycles
    task automatic run_seconds(input int n);
        int cycles;
        cycles = n * TICK_DIV + 2;
        if (model_field == 0) begin
            cycles -= phase;
        end
        repeat (cycles) clock_step();
    endtask

    task automatic press_mode(input int n);
        repeat (n) begin
            mode_btn = 1'b1;
            clock_step();
            mode_btn = 1'b0;
            clock_step();
        end
    endtask

    // Command is registered in the FSM, so the time changes on the second edge
    task automatic press_inc(input int n);
        repeat (n) begin
            inc_btn = 1'b1;
            clock_step();
            inc_btn = 1'b0;
            clock_step();
        end
    endtask

    task automatic run_command(input string cmd, input int unsigned arg);
        if (cmd == "run") begin
            run_seconds(arg);
        end else if (cmd == "mode") begin
            press_mode(arg);
        end else if (cmd == "inc") begin
            press_inc(arg);
        end else if (cmd == "en") begin
            en = arg[0];
        end else if (cmd == "field") begin
            check_value("field", field, arg);
        end else if (cmd == "time") begin
            check_time(arg[23:0]);
        end else begin
            $display("Unknown command %s in the stimulus file", cmd);
            error_count++;
        end
    endtask

    task automatic watchdog(input int limit);
        repeat (limit) @(posedge clk);
        $display("Timed out after %0d cycles, the stimulus did not complete", limit);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("Done: errors found");
        $finish;
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        rst_n    = 1'b0;
        en       = 1'b0;
        mode_btn = 1'b0;
        inc_btn  = 1'b0;
        read_stimulus();
        fork
            watchdog(2 * run_total * TICK_DIV + 1000);
        join_none
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("digit_sel", digit_sel, SEL_FIRST);
        foreach (cmd_q[i]) begin
            run_command(cmd_q[i], arg_q[i]);
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Display scan sampled mid cycle against the digits of the cycle before
    initial begin : scan_monitor
        logic [5:0]  prev_sel;
        logic [23:0] prev_time;
        int          pos;
        int          hold;
        prev_sel  = SEL_FIRST;
        prev_time = '0;
        pos       = 0;
        hold      = 0;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                check_value("digit_sel one-hot count", $countones(digit_sel), 1);
                hold++;
                if (digit_sel != prev_sel) begin
                    // Next position in display order, back to hour tens after second ones
                    pos  = (pos + 1) % 6;
                    hold = 0;
                    check_value("digit_sel", digit_sel, SEL_FIRST >> pos);
                end else if (hold > SCAN_DIV) begin
                    $display("At time %0t digit_sel did not move for more than %0d cycles",
                             $time, SCAN_DIV);
                    error_count++;
                    hold = 0;
                end
                check_value("digit_val", digit_val, selected_digit(digit_sel, prev_time));
            end
            prev_sel  = digit_sel;
            prev_time = {hour_10, hour_1, minute_10, minute_1, second_10, second_1};
        end
    end

endmodule

/* project.f */
+incdir+common
common/rtc_pkg.sv
src/tick_prescaler.sv
src/rtc_set_fsm.sv
time_counter/bcd_time_counter.sv
src/display_scan.sv
src/rtc_top.sv
dv/rtc_tb.sv

/* src/display_scan.sv */
module display_scan (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          scan,
    input  rtc_pkg::bcd_t hour_10,
    input  rtc_pkg::bcd_t hour_1,
    input  rtc_pkg::bcd_t minute_10,
    input  rtc_pkg::bcd_t minute_1,
    input  rtc_pkg::bcd_t second_10,
    input  rtc_pkg::bcd_t second_1,
    output logic [5:0]    digit_sel,
    output rtc_pkg::bcd_t digit_val
);

    // Bit 5 drives the hour tens position, bit 0 the second ones
    localparam logic [5:0] SEL_FIRST = 6'b100000;

    rtc_pkg::bcd_t digits [6];
    logic [5:0]    sel_next;
    rtc_pkg::bcd_t val_next;

    assign digits = '{hour_10, hour_1, minute_10, minute_1, second_10, second_1};

    ////////////////////////////////////////////////
    // Digit select
    ////////////////////////////////////////////////

    // Rotate right so the seconds ones wraps back to hour tens
    assign sel_next = scan ? {digit_sel[0], digit_sel[5:1]} : digit_sel;

    always_comb begin
        val_next = 4'd0;
        for (int i = 0; i < 6; i++) begin
            if (sel_next[5-i]) begin
                val_next = digits[i];
            end
        end
    end

    // Value follows the select every cycle so it tracks time updates
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digit_sel <= SEL_FIRST;
            digit_val <= 4'd0;
        end else begin
            digit_sel <= sel_next;
            digit_val <= val_next;
        end
    end

    a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(digit_sel));

endmodule

/* src/rtc_set_fsm.sv */
module rtc_set_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mode_btn,
    input  logic                inc_btn,
    output rtc_pkg::set_field_t field,
    output logic                run,
    output logic                inc_hour,
    output logic                inc_min,
    output logic                clr_sec
);

    rtc_pkg::set_field_t field_next;
    logic                inc_ok;

    ////////////////////////////////////////////////
    // Mode sequencing
    ////////////////////////////////////////////////

    // RUN -> hours -> minutes -> seconds -> RUN
    always_comb begin
        field_next = field;
        if (mode_btn) begin
            case (field)
                rtc_pkg::RUN:      field_next = rtc_pkg::SET_HOUR;
                rtc_pkg::SET_HOUR: field_next = rtc_pkg::SET_MIN;
                rtc_pkg::SET_MIN:  field_next = rtc_pkg::SET_SEC;
                rtc_pkg::SET_SEC:  field_next = rtc_pkg::RUN;
                default:           field_next = rtc_pkg::RUN;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            field <= rtc_pkg::RUN;
        end else begin
            field <= field_next;
        end
    end

    // Time only advances in RUN
    assign run = (field == rtc_pkg::RUN);

    ////////////////////////////////////////////////
    // Field commands
    ////////////////////////////////////////////////

    // An inc together with a mode press is dropped, so a command
    // never lands in a different field than the one shown
    assign inc_ok = inc_btn && !mode_btn;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inc_hour <= 1'b0;
            inc_min  <= 1'b0;
            clr_sec  <= 1'b0;
        end else begin
            inc_hour <= inc_ok && (field == rtc_pkg::SET_HOUR);
            inc_min  <= inc_ok && (field == rtc_pkg::SET_MIN);
            clr_sec  <= inc_ok && (field == rtc_pkg::SET_SEC);
        end
    end

    // Commands are exclusive and never reach the counter while it runs
    a_cmd_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({inc_hour, inc_min, clr_sec}));

    a_cmd_not_in_run: assert property (@(posedge clk) disable iff (!rst_n)
        run |-> !(inc_hour || inc_min || clr_sec));

endmodule

/* src/rtc_top.sv */
`include "rtc_macros.svh"

module rtc_top #(
    parameter int unsigned tick_div = `RTC_TICK_DIV,
    parameter int unsigned scan_div = `RTC_SCAN_DIV
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                en,
    input  logic                mode_btn,
    input  logic                inc_btn,
    output rtc_pkg::set_field_t field,
    output rtc_pkg::bcd_t       hour_10,
    output rtc_pkg::bcd_t       hour_1,
    output rtc_pkg::bcd_t       minute_10,
    output rtc_pkg::bcd_t       minute_1,
    output rtc_pkg::bcd_t       second_10,
    output rtc_pkg::bcd_t       second_1,
    output logic [5:0]          digit_sel,
    output rtc_pkg::bcd_t       digit_val
);

    logic run;
    logic tick;
    logic scan;
    logic inc_hour;
    logic inc_min;
    logic clr_sec;

    ////////////////////////////////////////////////
    // Timing and control
    ////////////////////////////////////////////////

    tick_prescaler #(
        .tick_div (tick_div),
        .scan_div (scan_div)
    ) prescaler_i (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (run),
        .tick  (tick),
        .scan  (scan)
    );

    rtc_set_fsm set_fsm_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .mode_btn (mode_btn),
        .inc_btn  (inc_btn),
        .field    (field),
        .run      (run),
        .inc_hour (inc_hour),
        .inc_min  (inc_min),
        .clr_sec  (clr_sec)
    );

    ////////////////////////////////////////////////
    // Time keeping and display
    ////////////////////////////////////////////////

    bcd_time_counter counter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .run       (run),
        .tick      (tick),
        .inc_hour  (inc_hour),
        .inc_min   (inc_min),
        .clr_sec   (clr_sec),
        .hour_10   (hour_10),
        .hour_1    (hour_1),
        .minute_10 (minute_10),
        .minute_1  (minute_1),
        .second_10 (second_10),
        .second_1  (second_1)
    );

    display_scan scan_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .scan      (scan),
        .hour_10   (hour_10),
        .hour_1    (hour_1),
        .minute_10 (minute_10),
        .minute_1  (minute_1),
        .second_10 (second_10),
        .second_1  (second_1),
        .digit_sel (digit_sel),
        .digit_val (digit_val)
    );

endmodule

/* src/tick_prescaler.sv */
`include "rtc_macros.svh"

module tick_prescaler #(
    parameter int unsigned tick_div = `RTC_TICK_DIV,
    parameter int unsigned scan_div = `RTC_SCAN_DIV
) (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    output logic tick,
    output logic scan
);

    localparam int unsigned TICK_W = (tick_div > 1) ? $clog2(tick_div) : 1;
    localparam int unsigned SCAN_W = (scan_div > 1) ? $clog2(scan_div) : 1;

    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(tick_div - 1);
    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(scan_div - 1);

    logic [TICK_W-1:0] tick_cnt;
    logic [SCAN_W-1:0] scan_cnt;

    ////////////////////////////////////////////////
    // One-second divider
    ////////////////////////////////////////////////

    // Held at zero outside RUN so a freshly set time gets a full second
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
        end else if (!run || tick_cnt == TICK_LAST) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    assign tick = run && (tick_cnt == TICK_LAST);

    ////////////////////////////////////////////////
    // Scan divider
    ////////////////////////////////////////////////

    // Free running, the display keeps scanning in set mode too
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_cnt <= '0;
        end else if (scan_cnt == SCAN_LAST) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign scan = (scan_cnt == SCAN_LAST);

    // A second never lasts a single cycle
    a_tick_single: assert property (@(posedge clk) disable iff (!rst_n)
        (tick_div > 1 && tick) |=> !tick);

endmodule

/* time_counter/bcd_time_counter.sv */
`include "rtc_macros.svh"

module bcd_time_counter (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          en,
    input  logic          run,
    input  logic          tick,
    input  logic          inc_hour,
    input  logic          inc_min,
    input  logic          clr_sec,
    output rtc_pkg::bcd_t hour_10,
    output rtc_pkg::bcd_t hour_1,
    output rtc_pkg::bcd_t minute_10,
    output rtc_pkg::bcd_t minute_1,
    output rtc_pkg::bcd_t second_10,
    output rtc_pkg::bcd_t second_1
);

    ////////////////////////////////////////////////
    // Digit limits
    ////////////////////////////////////////////////

    localparam rtc_pkg::bcd_t ONES_LAST = 4'd9;

    // Tens of minutes and seconds, 5 for a 60 count
    localparam rtc_pkg::bcd_t TENS_LAST = rtc_pkg::bcd_t'(`RTC_MINUTES_PER_HOUR / 10 - 1);

    // Last hour of the day split into digits, 2 and 3
    localparam int unsigned   HOUR_LAST      = `RTC_HOURS_PER_DAY - 1;
    localparam rtc_pkg::bcd_t HOUR_TENS_LAST = rtc_pkg::bcd_t'(HOUR_LAST / 10);
    localparam rtc_pkg::bcd_t HOUR_ONES_LAST = rtc_pkg::bcd_t'(HOUR_LAST % 10);

    logic step;
    logic sec_1_max;
    logic sec_10_max;
    logic min_1_max;
    logic min_10_max;
    logic hour_max;
    logic sec_carry;
    logic min_adv;
    logic hour_adv;

    function automatic rtc_pkg::bcd_t wrap_inc(input rtc_pkg::bcd_t d,
                                               input rtc_pkg::bcd_t last);
        return (d == last) ? 4'd0 : d + 4'd1;
    endfunction

    ////////////////////////////////////////////////
    // Carry chain
    ////////////////////////////////////////////////

    assign step = run && en && tick;

    assign sec_1_max  = (second_1 == ONES_LAST);
    assign sec_10_max = (second_10 == TENS_LAST);
    assign min_1_max  = (minute_1 == ONES_LAST);
    assign min_10_max = (minute_10 == TENS_LAST);
    assign hour_max   = (hour_10 == HOUR_TENS_LAST) && (hour_1 == HOUR_ONES_LAST);

    // Whole chain settles in the same cycle, all digits roll on one edge
    assign sec_carry = step && sec_1_max && sec_10_max;

    // Set commands act on one field, inc_min never carries into hours
    assign min_adv  = sec_carry || inc_min;
    assign hour_adv = (sec_carry && min_1_max && min_10_max) || inc_hour;

    ////////////////////////////////////////////////
    // Seconds
    ////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            second_1  <= 4'd0;
            second_10 <= 4'd0;
        end else if (clr_sec) begin
            second_1  <= 4'd0;
            second_10 <= 4'd0;
        end else if (step) begin
            second_1 <= wrap_inc(second_1, ONES_LAST);
            if (sec_1_max) begin
                second_10 <= wrap_inc(second_10, TENS_LAST);
            end
        end
    end

    ////////////////////////////////////////////////
    // Minutes
    ////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            minute_1  <= 4'd0;
            minute_10 <= 4'd0;
        end else if (min_adv) begin
            minute_1 <= wrap_inc(minute_1, ONES_LAST);
            if (min_1_max) begin
                minute_10 <= wrap_inc(minute_10, TENS_LAST);
            end
        end
    end

    ////////////////////////////////////////////////
    // Hours
    ////////////////////////////////////////////////

    // Both digits clear at end of day, hour_1 wraps at 9 before that
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hour_1  <= 4'd0;
            hour_10 <= 4'd0;
        end else if (hour_adv) begin
            if (hour_max) begin
                hour_1  <= 4'd0;
                hour_10 <= 4'd0;
            end else if (hour_1 == ONES_LAST) begin
                hour_1  <= 4'd0;
                hour_10 <= hour_10 + 4'd1;
            end else begin
                hour_1 <= hour_1 + 4'd1;
            end
        end
    end

    // Digit ranges
    a_digit_range: assert property (@(posedge clk) disable iff (!rst_n)
        second_1 <= ONES_LAST && second_10 <= TENS_LAST &&
        minute_1 <= ONES_LAST && minute_10 <= TENS_LAST &&
        hour_1 <= ONES_LAST && hour_10 <= HOUR_TENS_LAST);

    a_hour_range: assert property (@(posedge clk) disable iff (!rst_n)
        (int'(hour_10) * 10 + int'(hour_1)) < `RTC_HOURS_PER_DAY);

endmodule
